// File: logic/rv_core_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// ----------------------------------------------------------------------
// Core sizing
// ----------------------------------------------------------------------

// Integer data path width
`define RV_XLEN 32

// Architectural registers x0 to x31
`define RV_NREGS 32
`define RV_REG_AW 5

// Scoreboard counter, up to three writes to one register in flight
`define RV_PEND_W 2

`endif

// File: logic/rv_core_pkg.sv
`include "rv_core_defs.svh"

package rv_core_pkg;

    // ------------------------------------------------------------------
    // Data path types
    // ------------------------------------------------------------------

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // Pending writes per register
    typedef logic [`RV_PEND_W-1:0] pend_cnt_t;

    // Operations of the ALU stage
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    // ------------------------------------------------------------------
    // RV32I encodings
    // ------------------------------------------------------------------

    // Major opcodes, register and immediate forms
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3, ADDI shares the ADD/SUB code
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

// File: logic/instr_decoder.sv
module instr_decoder
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // Fetch side
    input  logic      instr_valid_i,
    input  word_t     instr_i,
    input  logic      stall_i,

    // Decoded instruction to the register file
    output logic      dec_valid_o,
    output reg_addr_t dec_rs1_o,
    output reg_addr_t dec_rs2_o,
    output reg_addr_t dec_rd_o,
    output alu_op_t   dec_op_o,
    output word_t     dec_imm_o,
    output logic      dec_use_imm_o,
    output logic      dec_writes_rd_o,
    output logic      illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    alu_op_t    op;
    logic       use_imm;

    // Instruction fields
    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // ------------------------------------------------------------------
    // Opcode / funct decode
    // ------------------------------------------------------------------

    always_comb begin
        legal   = 1'b0;
        op      = ALU_ADD;
        use_imm = 1'b0;
        case (opcode)
            OPC_OP: begin
                // Only SUB may carry a nonzero funct7
                legal = (funct7 == F7_BASE) ||
                        (funct7 == F7_SUB && funct3 == F3_ADD_SUB);
                case (funct3)
                    F3_ADD_SUB: op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:     op = ALU_SLT;
                    F3_XOR:     op = ALU_XOR;
                    F3_OR:      op = ALU_OR;
                    F3_AND:     op = ALU_AND;
                    default:    legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // ADDI only
                legal   = (funct3 == F3_ADD_SUB);
                op      = ALU_ADD;
                use_imm = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // Control, held while the register file stalls
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            dec_valid_o <= 1'b0;
            illegal_o   <= 1'b0;
        end else begin
            if (!stall_i) begin
                dec_valid_o <= instr_valid_i && legal;
            end
            // One pulse per dropped word
            illegal_o <= instr_valid_i && !stall_i && !legal;
        end
    end

    // Decoded payload
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            dec_rs1_o       <= instr_i[19:15];
            dec_rs2_o       <= instr_i[24:20];
            dec_rd_o        <= instr_i[11:7];
            dec_op_o        <= op;
            // Sign-extended I-type immediate
            dec_imm_o       <= word_t'($signed(instr_i[31:20]));
            dec_use_imm_o   <= use_imm;
            dec_writes_rd_o <= legal;
        end
    end

endmodule

// File: logic/register_file.sv
`include "rv_core_defs.svh"

module register_file
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // From the decoder
    input  logic      dec_valid_i,
    input  reg_addr_t dec_rs1_i,
    input  reg_addr_t dec_rs2_i,
    input  reg_addr_t dec_rd_i,
    input  alu_op_t   dec_op_i,
    input  word_t     dec_imm_i,
    input  logic      dec_use_imm_i,
    input  logic      dec_writes_rd_i,

    // From write-back
    input  logic      wb_write_i,
    input  reg_addr_t wb_rd_i,
    input  word_t     wb_data_i,

    // Issue to the ALU stage
    output logic      stall_o,
    output logic      iss_valid_o,
    output word_t     iss_rs1_data_o,
    output word_t     iss_rs2_data_o,
    output word_t     iss_imm_o,
    output logic      iss_use_imm_o,
    output alu_op_t   iss_op_o,
    output reg_addr_t iss_rd_o
);

    word_t               regs_q [`RV_NREGS];
    pend_cnt_t           pend_q [`RV_NREGS];
    logic [`RV_NREGS-1:0] pend_inc;
    logic [`RV_NREGS-1:0] pend_dec;
    logic                rs1_busy;
    logic                rs2_busy;
    logic                issue;

    // ------------------------------------------------------------------
    // Scoreboard check
    // ------------------------------------------------------------------

    // Counters read before this cycle's decrement
    assign rs1_busy = (pend_q[dec_rs1_i] != '0);
    assign rs2_busy = (pend_q[dec_rs2_i] != '0) && !dec_use_imm_i;
    assign stall_o  = dec_valid_i && (rs1_busy || rs2_busy);
    assign issue    = dec_valid_i && !stall_o;

    // One-hot counter updates
    always_comb begin
        pend_inc = '0;
        pend_dec = '0;
        // x0 is never scored
        if (issue && dec_writes_rd_i && dec_rd_i != '0) begin
            pend_inc[dec_rd_i] = 1'b1;
        end
        if (wb_write_i) begin
            pend_dec[wb_rd_i] = 1'b1;
        end
    end

    // Register array and pending counters
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs_q[i] <= '0;
                pend_q[i] <= '0;
            end
        end else begin
            if (wb_write_i && wb_rd_i != '0) begin
                regs_q[wb_rd_i] <= wb_data_i;
            end
            for (int i = 0; i < `RV_NREGS; i++) begin
                // Issue and write-back on one register cancel out
                if (pend_inc[i] && !pend_dec[i]) begin
                    pend_q[i] <= pend_q[i] + pend_cnt_t'(1);
                end else if (pend_dec[i] && !pend_inc[i]) begin
                    pend_q[i] <= pend_q[i] - pend_cnt_t'(1);
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Issue register
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            iss_valid_o <= 1'b0;
        end else begin
            iss_valid_o <= issue;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            // x0 always reads zero
            iss_rs1_data_o <= (dec_rs1_i == '0) ? '0 : regs_q[dec_rs1_i];
            iss_rs2_data_o <= (dec_rs2_i == '0) ? '0 : regs_q[dec_rs2_i];
            iss_imm_o      <= dec_imm_i;
            iss_use_imm_o  <= dec_use_imm_i;
            iss_op_o       <= dec_op_i;
            iss_rd_o       <= dec_rd_i;
        end
    end

endmodule

// File: logic/alu_stage.sv
module alu_stage
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // Issued operands
    input  logic      iss_valid_i,
    input  word_t     iss_rs1_data_i,
    input  word_t     iss_rs2_data_i,
    input  word_t     iss_imm_i,
    input  logic      iss_use_imm_i,
    input  alu_op_t   iss_op_i,
    input  reg_addr_t iss_rd_i,

    // Result to write-back
    output logic      alu_valid_o,
    output reg_addr_t alu_rd_o,
    output word_t     alu_result_o
);

    word_t op_a;
    word_t op_b;
    word_t result;

    // Second operand, immediate form or rs2
    assign op_a = iss_rs1_data_i;
    assign op_b = iss_use_imm_i ? iss_imm_i : iss_rs2_data_i;

    // ------------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------------

    always_comb begin
        case (iss_op_i)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            // Signed compare, zero-extended flag
            ALU_SLT: result = word_t'($signed(op_a) < $signed(op_b));
            default: result = '0;
        endcase
    end

    // Valid bit
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            alu_valid_o <= 1'b0;
        end else begin
            alu_valid_o <= iss_valid_i;
        end
    end

    // Result and destination
    always_ff @(posedge clk_i) begin
        if (iss_valid_i) begin
            alu_rd_o     <= iss_rd_i;
            alu_result_o <= result;
        end
    end

endmodule

// File: logic/writeback_stage.sv
module writeback_stage
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // From the ALU stage
    input  logic      alu_valid_i,
    input  reg_addr_t alu_rd_i,
    input  word_t     alu_result_i,

    // Register file write port
    output logic      wb_write_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o,

    // Retire port
    output logic      retire_valid_o,
    output reg_addr_t retire_rd_o,
    output word_t     retire_data_o,
    output word_t     retire_count_o
);

    // Control and retire counter
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            wb_write_o     <= 1'b0;
            retire_valid_o <= 1'b0;
            retire_count_o <= '0;
        end else begin
            // x0 is never written
            wb_write_o     <= alu_valid_i && (alu_rd_i != '0);
            retire_valid_o <= alu_valid_i;
            if (alu_valid_i) begin
                retire_count_o <= retire_count_o + word_t'(1);
            end
        end
    end

    // Payload, zero data shown for x0
    always_ff @(posedge clk_i) begin
        if (alu_valid_i) begin
            wb_rd_o   <= alu_rd_i;
            wb_data_o <= (alu_rd_i == '0) ? '0 : alu_result_i;
        end
    end

    // Retire mirrors the write port
    assign retire_rd_o   = wb_rd_o;
    assign retire_data_o = wb_data_o;

endmodule

// File: logic/rv_core_top.sv
module rv_core_top
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // Fetch side
    input  logic      instr_valid_i,
    input  word_t     instr_i,
    output logic      stall_o,

    // Retire side
    output logic      retire_valid_o,
    output reg_addr_t retire_rd_o,
    output word_t     retire_data_o,
    output word_t     retire_count_o,
    output logic      illegal_o
);

    // Decoder to register file
    logic      dec_valid;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    reg_addr_t dec_rd;
    alu_op_t   dec_op;
    word_t     dec_imm;
    logic      dec_use_imm;
    logic      dec_writes_rd;
    logic      stall;

    // Register file to ALU
    logic      iss_valid;
    word_t     iss_rs1_data;
    word_t     iss_rs2_data;
    word_t     iss_imm;
    logic      iss_use_imm;
    alu_op_t   iss_op;
    reg_addr_t iss_rd;

    // ALU to write-back
    logic      alu_valid;
    reg_addr_t alu_rd;
    word_t     alu_result;

    // Write-back to register file
    logic      wb_write;
    reg_addr_t wb_rd;
    word_t     wb_data;

    // Fetch holds its word on this level
    assign stall_o = stall;

    // ------------------------------------------------------------------
    // Pipeline
    // ------------------------------------------------------------------

    instr_decoder u_decoder (
        .clk_i(clk_i), .rst_i(rst_i),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i), .stall_i(stall),
        .dec_valid_o(dec_valid), .dec_rs1_o(dec_rs1), .dec_rs2_o(dec_rs2),
        .dec_rd_o(dec_rd), .dec_op_o(dec_op), .dec_imm_o(dec_imm),
        .dec_use_imm_o(dec_use_imm), .dec_writes_rd_o(dec_writes_rd),
        .illegal_o(illegal_o)
    );

    register_file u_regfile (
        .clk_i(clk_i), .rst_i(rst_i),
        .dec_valid_i(dec_valid), .dec_rs1_i(dec_rs1), .dec_rs2_i(dec_rs2),
        .dec_rd_i(dec_rd), .dec_op_i(dec_op), .dec_imm_i(dec_imm),
        .dec_use_imm_i(dec_use_imm), .dec_writes_rd_i(dec_writes_rd),
        .wb_write_i(wb_write), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .stall_o(stall), .iss_valid_o(iss_valid),
        .iss_rs1_data_o(iss_rs1_data), .iss_rs2_data_o(iss_rs2_data),
        .iss_imm_o(iss_imm), .iss_use_imm_o(iss_use_imm),
        .iss_op_o(iss_op), .iss_rd_o(iss_rd)
    );

    alu_stage u_alu (
        .clk_i(clk_i), .rst_i(rst_i),
        .iss_valid_i(iss_valid), .iss_rs1_data_i(iss_rs1_data),
        .iss_rs2_data_i(iss_rs2_data), .iss_imm_i(iss_imm),
        .iss_use_imm_i(iss_use_imm), .iss_op_i(iss_op), .iss_rd_i(iss_rd),
        .alu_valid_o(alu_valid), .alu_rd_o(alu_rd), .alu_result_o(alu_result)
    );

    writeback_stage u_wb (
        .clk_i(clk_i), .rst_i(rst_i),
        .alu_valid_i(alu_valid), .alu_rd_i(alu_rd), .alu_result_i(alu_result),
        .wb_write_o(wb_write), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .retire_valid_o(retire_valid_o), .retire_rd_o(retire_rd_o),
        .retire_data_o(retire_data_o), .retire_count_o(retire_count_o)
    );

endmodule

// File: tb/rv_core_tb.sv
module rv_core_tb
    import rv_core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NTBL = 25;
    localparam int NRAND = 40;
    // Chain of back-to-back dependent words in the table
    localparam int CHAIN_FIRST = 15;
    localparam int CHAIN_LAST = 18;
    localparam int MAX_CYCLES = 8 * (NTBL + NRAND) + 200;

    logic      clk_i;
    logic      rst_i;
    logic      instr_valid_i;
    word_t     instr_i;
    logic      stall_o;
    logic      retire_valid_o;
    reg_addr_t retire_rd_o;
    word_t     retire_data_o;
    word_t     retire_count_o;
    logic      illegal_o;

    // Table of words and expected destinations
    word_t     tbl_instr [NTBL];
    reg_addr_t tbl_rd [NTBL];

    // Reference model state
    word_t     ref_regs [32];
    reg_addr_t exp_rd_q [$];
    word_t     exp_data_q [$];
    int        legal_cnt;
    int        illegal_exp;
    int        illegal_seen;
    int        retired;
    int        cycle_cnt;
    integer    seed;

    rv_core_top dut0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i), .stall_o(stall_o),
        .retire_valid_o(retire_valid_o), .retire_rd_o(retire_rd_o),
        .retire_data_o(retire_data_o), .retire_count_o(retire_count_o),
        .illegal_o(illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------------

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input reg_addr_t got, input reg_addr_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is x%0d, expected x%0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------------
    // Instruction encoding
    // ------------------------------------------------------------------

    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    // ADDI only
    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rd,
                                     input reg_addr_t rs1);
        return {imm, rs1, F3_ADD_SUB, rd, OPC_OP_IMM};
    endfunction

    task automatic load_table();
        // Operand setup with positive and negative immediates
        tbl_instr[0]  = i_type(12'd100, 5'd1, 5'd0);
        tbl_instr[1]  = i_type(12'hff9, 5'd2, 5'd0);
        tbl_instr[2]  = i_type(12'h7ff, 5'd3, 5'd0);
        tbl_instr[3]  = i_type(12'h800, 5'd4, 5'd0);
        // Register-register ops
        tbl_instr[4]  = r_type(F7_BASE, F3_ADD_SUB, 5'd5, 5'd1, 5'd2);
        tbl_instr[5]  = r_type(F7_SUB, F3_ADD_SUB, 5'd6, 5'd1, 5'd3);
        tbl_instr[6]  = r_type(F7_BASE, F3_AND, 5'd7, 5'd3, 5'd4);
        tbl_instr[7]  = r_type(F7_BASE, F3_OR, 5'd8, 5'd2, 5'd3);
        tbl_instr[8]  = r_type(F7_BASE, F3_XOR, 5'd9, 5'd1, 5'd2);
        tbl_instr[9]  = r_type(F7_BASE, F3_SLT, 5'd10, 5'd2, 5'd1);
        tbl_instr[10] = r_type(F7_BASE, F3_SLT, 5'd11, 5'd1, 5'd2);
        // Unsupported load word
        tbl_instr[11] = 32'h0000_2083;
        // Writes to x0 and a later read of x0
        tbl_instr[12] = i_type(12'd5, 5'd0, 5'd1);
        tbl_instr[13] = r_type(F7_BASE, F3_ADD_SUB, 5'd0, 5'd1, 5'd2);
        tbl_instr[14] = r_type(F7_BASE, F3_ADD_SUB, 5'd12, 5'd0, 5'd1);
        // Dependent chain
        tbl_instr[15] = i_type(12'd1, 5'd13, 5'd12);
        tbl_instr[16] = i_type(12'd1, 5'd13, 5'd13);
        tbl_instr[17] = r_type(F7_BASE, F3_ADD_SUB, 5'd13, 5'd13, 5'd13);
        tbl_instr[18] = r_type(F7_SUB, F3_ADD_SUB, 5'd14, 5'd13, 5'd1);
        tbl_instr[19] = r_type(F7_BASE, F3_XOR, 5'd15, 5'd14, 5'd14);
        tbl_instr[20] = i_type(12'hfff, 5'd16, 5'd0);
        tbl_instr[21] = r_type(F7_BASE, F3_SLT, 5'd17, 5'd16, 5'd0);
        // MUL encoding with an unsupported funct7
        tbl_instr[22] = r_type(7'b0000001, F3_ADD_SUB, 5'd1, 5'd1, 5'd2);
        tbl_instr[23] = r_type(F7_BASE, F3_AND, 5'd18, 5'd16, 5'd12);
        tbl_instr[24] = r_type(F7_BASE, F3_OR, 5'd19, 5'd0, 5'd0);
        // Expected destinations of the words above
        tbl_rd = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5,
                   5'd6, 5'd7, 5'd8, 5'd9, 5'd10,
                   5'd11, 5'd1, 5'd0, 5'd0, 5'd12,
                   5'd13, 5'd13, 5'd13, 5'd14, 5'd15,
                   5'd16, 5'd17, 5'd1, 5'd18, 5'd19};
    endtask

    // ------------------------------------------------------------------
    // Reference model from the architectural RV32I rules
    // ------------------------------------------------------------------

    task automatic model_accept(input word_t w, input reg_addr_t exp_rd);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      res;
        logic       legal;
        opc = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        a = ref_regs[w[19:15]];
        b = ref_regs[w[24:20]];
        imm = {{20{w[31]}}, w[31:20]};
        legal = 1'b1;
        res = '0;
        if (opc == 7'b0010011 && f3 == 3'b000) res = a + imm;
        else if (opc == 7'b0110011 && f7 == 7'b0100000 && f3 == 3'b000) res = a - b;
        else if (opc == 7'b0110011 && f7 == 7'b0000000 && f3 == 3'b000) res = a + b;
        else if (opc == 7'b0110011 && f7 == 7'b0000000 && f3 == 3'b010)
            res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        else if (opc == 7'b0110011 && f7 == 7'b0000000 && f3 == 3'b100) res = a ^ b;
        else if (opc == 7'b0110011 && f7 == 7'b0000000 && f3 == 3'b110) res = a | b;
        else if (opc == 7'b0110011 && f7 == 7'b0000000 && f3 == 3'b111) res = a & b;
        else legal = 1'b0;
        if (legal) begin
            // x0 stays zero and retires zero
            if (w[11:7] != 5'd0) ref_regs[w[11:7]] = res;
            else res = '0;
            exp_rd_q.push_back(exp_rd);
            exp_data_q.push_back(res);
            legal_cnt++;
        end else begin
            illegal_exp++;
        end
    endtask

    // ------------------------------------------------------------------
    // Fetch side driver
    // ------------------------------------------------------------------

    // Word held until a cycle with stall low
    task automatic send_word(input word_t w, input reg_addr_t exp_rd, output bit stalled);
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i <= w;
        stalled = 1'b0;
        @(negedge clk_i);
        while (stall_o) begin
            stalled = 1'b1;
            @(negedge clk_i);
        end
        model_accept(w, exp_rd);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            instr_valid_i <= 1'b0;
        end
    endtask

    // Retire and illegal monitor on registered outputs
    always @(negedge clk_i) begin
        if (rst_i && illegal_o) illegal_seen++;
        if (rst_i && retire_valid_o) begin
            if (exp_data_q.size() == 0) begin
                report_problem("A retire pulse came with no instruction outstanding");
            end else begin
                check_addr(retire_rd_o, exp_rd_q.pop_front(),
                           $sformatf("retire %0d rd", retired));
                check_word(retire_data_o, exp_data_q.pop_front(),
                           $sformatf("retire %0d data", retired));
                retired++;
            end
        end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt == MAX_CYCLES) begin
            report_problem($sformatf("Run timed out after %0d cycles without draining",
                                     MAX_CYCLES));
        end
    end

    initial begin
        bit        stalled;
        int        chain_stalls;
        int        kind;
        word_t     r;
        word_t     w;
        seed = 32'h9833_1a06;
        rst_i = 1'b0;
        instr_valid_i = 1'b0;
        instr_i = '0;
        chain_stalls = 0;
        legal_cnt = 0;
        illegal_exp = 0;
        illegal_seen = 0;
        retired = 0;
        cycle_cnt = 0;
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        load_table();
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b1;

        // Directed table
        for (int i = 0; i < NTBL; i++) begin
            send_word(tbl_instr[i], tbl_rd[i], stalled);
            if (stalled && i >= CHAIN_FIRST && i <= CHAIN_LAST) chain_stalls++;
        end
        idle_cycles(1);
        if (chain_stalls == 0) begin
            report_problem("Stall never went high during the dependent chain");
        end

        // Random words with idle gaps
        for (int n = 0; n < NRAND; n++) begin
            r = $random(seed);
            kind = {$random(seed)} % 7;
            case (kind)
                0: w = r_type(F7_BASE, F3_ADD_SUB, r[11:7], r[19:15], r[24:20]);
                1: w = r_type(F7_SUB, F3_ADD_SUB, r[11:7], r[19:15], r[24:20]);
                2: w = r_type(F7_BASE, F3_AND, r[11:7], r[19:15], r[24:20]);
                3: w = r_type(F7_BASE, F3_OR, r[11:7], r[19:15], r[24:20]);
                4: w = r_type(F7_BASE, F3_XOR, r[11:7], r[19:15], r[24:20]);
                5: w = r_type(F7_BASE, F3_SLT, r[11:7], r[19:15], r[24:20]);
                default: w = i_type(r[31:20], r[11:7], r[19:15]);
            endcase
            send_word(w, r[11:7], stalled);
            idle_cycles({$random(seed)} % 4);
        end
        idle_cycles(1);

        // Drain and final counts
        while (exp_data_q.size() != 0) @(posedge clk_i);
        idle_cycles(4);
        @(negedge clk_i);
        check_word(retire_count_o, word_t'(legal_cnt), "retire count");
        check_word(word_t'(illegal_seen), word_t'(illegal_exp), "illegal pulse count");
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: sim.f
+incdir+logic
logic/rv_core_pkg.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/alu_stage.sv
logic/writeback_stage.sv
logic/rv_core_top.sv
tb/rv_core_tb.sv
